// File: hw/i2s_pkg.sv
package i2s_pkg;

    // Sizes
    localparam int data_w     = 32;
    localparam int fifo_aw    = 4;
    localparam int fifo_depth = 1 << fifo_aw;
    localparam int lvl_w      = fifo_aw + 1;         // Level counts 0 to fifo_depth
    localparam int cnt_w      = $clog2(data_w);      // Bits per channel slot

    // SCK generation, HCLK cycles per SCK half period
    localparam int sck_div = 2;
    localparam int div_w   = $clog2(sck_div);

    // Register map, compared on HADDR[7:0]
    localparam logic [7:0] ctrl_off   = 8'h00;
    localparam logic [7:0] status_off = 8'h04;
    localparam logic [7:0] data_off   = 8'h08;

    localparam logic [data_w-1:0] bad_data = 32'hbadd_beef;

    typedef enum logic [1:0] {
        rx_idle,                                     // Receiver off
        rx_sync,                                     // Running clocks, no word taken yet
        rx_shift                                     // Collecting words
    } rx_state_e;

    typedef enum logic [1:0] {
        idle   = 2'b00,
        busy   = 2'b01,
        nonseq = 2'b10,
        seq    = 2'b11
    } htrans_e;

    typedef struct packed {
        logic flush;                                 // Bit 1, clears itself
        logic enable;                                // Bit 0
    } ctrl_t;

    // Field order gives done at bit 0 and level at bits 9:5
    typedef struct packed {
        logic [lvl_w-1:0] level;
        logic             overflow;
        logic             full;
        logic             empty;
        logic             chan;
        logic             done;
    } status_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic              chan;                     // 0 left, 1 right
    } rx_word_t;

endpackage

// File: hw/i2s_rx.sv
module i2s_rx
    import i2s_pkg::*;
(
    input  logic     HCLK,
    input  logic     HRESETn,
    input  logic     enable,
    input  logic     sd,
    output logic     sck,
    output logic     ws,
    output rx_word_t word,
    output logic     word_valid
);

    rx_state_e         state;
    logic [div_w-1:0]  div_cnt;
    logic [cnt_w-1:0]  bit_cnt;
    logic [data_w-1:0] shift_q;
    logic              tick;
    logic              sck_rise;
    logic              sck_fall;
    logic              word_done;

    assign tick     = (div_cnt == div_w'(sck_div - 1));
    assign sck_rise = (state != rx_idle) && tick && !sck;
    assign sck_fall = (state != rx_idle) && tick && sck;

    // Slot 0 after a WS change carries the LSB of the previous word
    assign word_done = (state == rx_shift) && sck_rise && (bit_cnt == '0);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state      <= rx_idle;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            sck        <= 1'b0;
            ws         <= 1'b0;
            word_valid <= 1'b0;
        end else if (!enable) begin
            // Any partial word is simply abandoned
            state      <= rx_idle;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            sck        <= 1'b0;
            ws         <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_done;
            case (state)
                rx_idle: begin
                    // Open with a full right frame so the first word taken is left
                    state   <= rx_sync;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    ws      <= 1'b1;
                end
                default: begin
                    div_cnt <= tick ? '0 : div_cnt + 1'b1;
                    if (tick) begin
                        sck <= ~sck;
                    end
                    if (sck_fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == '1) begin
                            ws <= ~ws;               // WS moves on the falling edge
                        end
                    end
                    // Delay slot of the right frame has passed, left MSB is next
                    if (state == rx_sync && sck_rise && bit_cnt == '0 && !ws) begin
                        state <= rx_shift;
                    end
                end
            endcase
        end
    end

    // Shift register and output word
    always_ff @(posedge HCLK) begin
        if (sck_rise && state == rx_shift) begin
            shift_q <= {shift_q[data_w-2:0], sd};
        end
        if (word_done) begin
            word.data <= {shift_q[data_w-2:0], sd};
            word.chan <= ~ws;                        // WS has already moved to the next channel
        end
    end

endmodule

// File: hw/sample_fifo.sv
module sample_fifo
    import i2s_pkg::*;
(
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic              push,
    input  logic              pop,
    input  logic              flush,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] head,
    output logic              empty,
    output logic              full,
    output logic [lvl_w-1:0]  level
);

    logic [data_w-1:0]  mem [fifo_depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [lvl_w-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign empty   = (count == '0);
    assign full    = (count == lvl_w'(fifo_depth));
    assign level   = count;
    assign head    = mem[rd_ptr];                    // Oldest entry, shown without a pop

    assign do_push = push && !full;                  // Push on a full FIFO is lost
    assign do_pop  = pop && !empty;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge HCLK) begin
        if (do_push && !flush) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

// File: hw/ahbl_i2s.sv
module ahbl_i2s
    import i2s_pkg::*;
(
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic [31:0]       HADDR,
    input  logic [1:0]        HTRANS,
    input  logic              HWRITE,
    input  logic              HSEL,
    input  logic              HREADY,
    input  logic [2:0]        HSIZE,
    input  logic [31:0]       HWDATA,
    output logic [31:0]       HRDATA,
    output logic              HREADYOUT,
    output logic              enable,
    input  rx_word_t          word,
    input  logic              word_valid,
    output logic              push,
    output logic              pop,
    output logic              flush,
    output logic [data_w-1:0] fifo_wdata,
    input  logic [data_w-1:0] head,
    input  logic              empty,
    input  logic              full,
    input  logic [lvl_w-1:0]  level
);

    // Address phase
    logic [7:0] haddr_d;
    htrans_e    htrans_d;
    logic       hwrite_d;
    logic       hsel_d;

    // Register state
    ctrl_t      ctrl;
    logic       done;
    logic       chan;
    logic       overflow;
    status_t    status;

    logic       wr_en;
    logic       rd_en;
    logic       ctrl_sel;
    logic       status_sel;
    logic       data_sel;
    logic       status_rd;
    logic       data_rd;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            hsel_d   <= 1'b0;
            haddr_d  <= '0;
            htrans_d <= idle;
            hwrite_d <= 1'b0;
        end else if (HREADY) begin
            hsel_d <= HSEL;
            if (HSEL) begin
                haddr_d  <= HADDR[7:0];
                htrans_d <= htrans_e'(HTRANS);
                hwrite_d <= HWRITE;
            end
        end
    end

    assign wr_en      = hsel_d && htrans_d[1] && hwrite_d;   // NONSEQ or SEQ
    assign rd_en      = hsel_d && htrans_d[1] && !hwrite_d;
    assign ctrl_sel   = (haddr_d == ctrl_off);
    assign status_sel = (haddr_d == status_off);
    assign data_sel   = (haddr_d == data_off);
    assign status_rd  = rd_en && status_sel;
    assign data_rd    = rd_en && data_sel;

    // CTRL register
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            ctrl <= '0;
        end else if (wr_en && ctrl_sel) begin
            ctrl <= ctrl_t'(HWDATA[$bits(ctrl_t)-1:0]);
        end else begin
            ctrl.flush <= 1'b0;                      // One-cycle flush strobe
        end
    end

    assign enable = ctrl.enable;
    assign flush  = ctrl.flush;

    // Sticky flags, a new event beats a clearing read
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            done     <= 1'b0;
            chan     <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (word_valid) begin
                done <= 1'b1;
                chan <= word.chan;
            end else if (status_rd) begin
                done <= 1'b0;
            end
            if (word_valid && full) begin
                overflow <= 1'b1;                    // Word dropped
            end else if (status_rd) begin
                overflow <= 1'b0;
            end
        end
    end

    // FIFO side
    assign fifo_wdata = word.data;
    assign push       = word_valid && !full && !flush;
    assign pop        = data_rd && !empty && !flush;

    always_comb begin
        status.done     = done;
        status.chan     = chan;
        status.empty    = empty;
        status.full     = full;
        status.overflow = overflow;
        status.level    = level;
    end

    // Read mux in the data phase
    always_comb begin
        if (ctrl_sel) begin
            HRDATA = {{(data_w - $bits(ctrl_t)){1'b0}}, ctrl};
        end else if (status_sel) begin
            HRDATA = {{(data_w - $bits(status_t)){1'b0}}, status};
        end else if (data_sel) begin
            HRDATA = empty ? '0 : head;
        end else begin
            HRDATA = bad_data;
        end
    end

    assign HREADYOUT = 1'b1;                         // Zero wait states

endmodule

// File: hw/i2s_top.sv
module i2s_top
    import i2s_pkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic [31:0] HADDR,
    input  logic [1:0]  HTRANS,
    input  logic        HWRITE,
    input  logic        HSEL,
    input  logic        HREADY,
    input  logic [2:0]  HSIZE,
    input  logic [31:0] HWDATA,
    output logic [31:0] HRDATA,
    output logic        HREADYOUT,
    input  logic        SD,
    output logic        SCK,
    output logic        WS,
    output logic        full
);

    logic              enable;
    rx_word_t          word;
    logic              word_valid;
    logic              push;
    logic              pop;
    logic              flush;
    logic [data_w-1:0] fifo_wdata;
    logic [data_w-1:0] head;
    logic              empty;
    logic [lvl_w-1:0]  level;

    ahbl_i2s u_bus (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HADDR      (HADDR),
        .HTRANS     (HTRANS),
        .HWRITE     (HWRITE),
        .HSEL       (HSEL),
        .HREADY     (HREADY),
        .HSIZE      (HSIZE),
        .HWDATA     (HWDATA),
        .HRDATA     (HRDATA),
        .HREADYOUT  (HREADYOUT),
        .enable     (enable),
        .word       (word),
        .word_valid (word_valid),
        .push       (push),
        .pop        (pop),
        .flush      (flush),
        .fifo_wdata (fifo_wdata),
        .head       (head),
        .empty      (empty),
        .full       (full),
        .level      (level)
    );

    i2s_rx u_rx (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .enable     (enable),
        .sd         (SD),
        .sck        (SCK),
        .ws         (WS),
        .word       (word),
        .word_valid (word_valid)
    );

    sample_fifo u_fifo (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .push    (push),
        .pop     (pop),
        .flush   (flush),
        .wdata   (fifo_wdata),
        .head    (head),
        .empty   (empty),
        .full    (full),
        .level   (level)
    );

endmodule

// File: testbench/i2s_tb_assert.sv
module i2s_tb_assert
    import i2s_pkg::*;
(
    input logic             HCLK,
    input logic             HRESETn,
    input logic             HREADYOUT,
    input logic             word_valid,
    input logic             push,
    input logic             pop,
    input logic             flush,
    input logic [lvl_w-1:0] level
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;                                // Read by the testbench at the end

    flush_excl: assert property (@(posedge HCLK) disable iff (!HRESETn)
        flush |-> !(push || pop))
        else begin
            fail_cnt++;
            $error("push or pop high while flush is high");
        end

    ready_high: assert property (@(posedge HCLK) disable iff (!HRESETn) HREADYOUT)
        else begin
            fail_cnt++;
            $error("HREADYOUT went low");
        end

    // One HCLK per finished word
    valid_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
        word_valid |=> !word_valid)
        else begin
            fail_cnt++;
            $error("word_valid held for more than one cycle");
        end

    // A push that lands raises the level, which a full FIFO cannot do
    push_not_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
        push && !pop |=> level == $past(level) + 1'b1)
        else begin
            fail_cnt++;
            $error("push did not raise the FIFO level, the FIFO was full");
        end

endmodule

bind ahbl_i2s i2s_tb_assert u_assert (.*);

// File: testbench/i2s_tb.sv
module i2s_tb
    import i2s_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [data_w-1:0] bits;                     // Send order, first bit at index 0
        logic              chan;
    } sent_t;

    localparam int timeout_cycles = 40 * 128 + 2000;

    logic              HCLK;
    logic              HRESETn;
    logic [31:0]       HADDR;
    logic [1:0]        HTRANS;
    logic              HWRITE;
    logic              HSEL;
    logic              HREADY;
    logic [2:0]        HSIZE;
    logic [31:0]       HWDATA;
    logic [31:0]       HRDATA;
    logic              HREADYOUT;
    logic              SD;
    logic              SCK;
    logic              WS;
    logic              full;

    sent_t             words [$];                    // Every word the source completed
    logic              rx_on;
    int                cycles      = 0;
    int                data_errs   = 0;
    int                status_errs = 0;
    int                flag_errs   = 0;
    int                other_errs  = 0;

    i2s_top dut_i (.*);

    initial begin
        HCLK = 1'b0;
        forever #50 HCLK = ~HCLK;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // MSB first after the delay slot, LSB sits in the next delay slot
    function automatic logic [data_w-1:0] exp_word(input sent_t s);
        logic [data_w-1:0] w;
        for (int i = 0; i < data_w; i++) begin
            w[cnt_w'(data_w - 1 - i)] = s.bits[cnt_w'(i)];
        end
        return w;
    endfunction

    task automatic check_data(input string name, input logic [data_w-1:0] exp,
                              input logic [data_w-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_status(input string name, input status_t exp, input status_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            status_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            flag_errs++;
        end
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge HCLK);
        HSEL   = 1'b1;
        HTRANS = nonseq;
        HADDR  = {24'h0, addr};
        HWRITE = 1'b1;
        @(negedge HCLK);
        HSEL   = 1'b0;
        HTRANS = idle;
        HWDATA = data;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge HCLK);
        HSEL   = 1'b1;
        HTRANS = nonseq;
        HADDR  = {24'h0, addr};
        HWRITE = 1'b0;
        @(negedge HCLK);
        HSEL   = 1'b0;
        HTRANS = idle;
        data   = HRDATA;                             // Data phase, from the registered address
        check_flag("hreadyout", 1'b1, HREADYOUT);
    endtask

    task automatic read_status(output status_t s);
        logic [31:0] r;
        bus_read(status_off, r);
        s = status_t'(r[$bits(status_t)-1:0]);
    endtask

    task automatic start_rx(output int base);
        base  = words.size();
        rx_on = 1'b1;
        bus_write(ctrl_off, 32'h1);
    endtask

    // I2S source, a new bit after every falling SCK edge
    initial begin
        logic [31:0]       lfsr;
        logic              sck_last;
        logic              ws_last;
        logic              collecting;
        logic [data_w-1:0] frame;
        int                pos;
        lfsr       = 32'hdd1d_5e9b;
        SD         = 1'b0;
        sck_last   = 1'b0;
        ws_last    = 1'b0;
        collecting = 1'b0;
        frame      = '0;
        pos        = 0;
        forever begin
            @(negedge HCLK);
            if (!rx_on) begin
                ws_last    = 1'b0;
                collecting = 1'b0;
            end else if (sck_last && !SCK) begin
                lfsr = lfsr_next(lfsr);
                SD   = lfsr[0];
                if (WS != ws_last) begin             // Delay slot
                    if (collecting) begin
                        frame[data_w-1] = lfsr[0];
                        words.push_back(sent_t'{bits: frame, chan: ws_last});
                    end
                    collecting = collecting || !WS;  // First left frame opens the stream
                    pos        = 0;
                end else begin
                    pos++;
                    frame[cnt_w'(pos - 1)] = lfsr[0];
                end
                ws_last = WS;
            end
            sck_last = SCK;
        end
    end

    always @(posedge HCLK) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        status_t     st;
        status_t     exp_s;
        logic [31:0] rd;
        int          base;
        HRESETn = 1'b0;
        HADDR   = '0;
        HTRANS  = idle;
        HWRITE  = 1'b0;
        HSEL    = 1'b0;
        HREADY  = 1'b1;
        HSIZE   = 3'b010;
        HWDATA  = '0;
        rx_on   = 1'b0;
        repeat (4) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;

        // Reset values
        bus_read(ctrl_off, rd);
        check_data("reset ctrl", '0, rd);
        read_status(st);
        exp_s       = '0;
        exp_s.empty = 1'b1;
        check_status("reset status", exp_s, st);
        repeat (20) begin
            @(negedge HCLK);
            if (SCK || WS) begin
                $display("SCK or WS toggled while the receiver is disabled");
                other_errs++;
            end
        end

        // Streaming, one read per word
        start_rx(base);
        for (int i = 0; i < 12; i++) begin
            do begin
                read_status(st);
            end while (st.level == '0);
            exp_s       = '0;
            exp_s.done  = 1'b1;
            exp_s.chan  = 1'(i % 2);                 // Left first
            exp_s.level = lvl_w'(1);
            check_status("stream status", exp_s, st);
            bus_read(data_off, rd);
            check_data("stream data", exp_word(words[base + i]), rd);
        end

        // Sticky done
        do begin
            read_status(st);
        end while (!st.done);
        exp_s       = '0;
        exp_s.done  = 1'b1;
        exp_s.chan  = words[base + 12].chan;
        exp_s.level = lvl_w'(1);
        check_status("done set", exp_s, st);
        read_status(st);
        exp_s.done = 1'b0;
        check_status("done cleared", exp_s, st);
        bus_read(data_off, rd);
        check_data("done data", exp_word(words[base + 12]), rd);

        // Overflow with no reads for 20 words
        rx_on = 1'b0;
        bus_write(ctrl_off, 32'h0);
        start_rx(base);
        while (words.size() < base + 20) @(negedge HCLK);
        repeat (8) @(negedge HCLK);
        rx_on = 1'b0;
        bus_write(ctrl_off, 32'h0);
        read_status(st);
        exp_s          = '0;
        exp_s.done     = 1'b1;
        exp_s.chan     = words[base + 19].chan;
        exp_s.full     = 1'b1;
        exp_s.overflow = 1'b1;
        exp_s.level    = lvl_w'(fifo_depth);
        check_status("overflow status", exp_s, st);
        check_flag("full port set", 1'b1, full);
        for (int i = 0; i < fifo_depth; i++) begin
            bus_read(data_off, rd);
            check_data("overflow data", exp_word(words[base + i]), rd);
        end
        read_status(st);
        exp_s.done     = 1'b0;
        exp_s.full     = 1'b0;
        exp_s.overflow = 1'b0;
        exp_s.empty    = 1'b1;
        exp_s.level    = '0;
        check_status("overflow cleared", exp_s, st);
        check_flag("full port cleared", 1'b0, full);

        // Flush, unmapped offset and empty read
        start_rx(base);
        do begin
            read_status(st);
        end while (st.level < lvl_w'(2));
        rx_on = 1'b0;
        bus_write(ctrl_off, 32'h2);                  // Flush with the receiver off
        read_status(st);
        exp_s       = '0;
        exp_s.chan  = 1'b1;                          // Second word is right
        exp_s.empty = 1'b1;
        check_status("flush status", exp_s, st);
        bus_read(ctrl_off, rd);
        check_data("flush self clear", '0, rd);
        bus_read(8'h0c, rd);
        check_data("unmapped", bad_data, rd);
        bus_read(data_off, rd);
        check_data("empty data", '0, rd);

        other_errs += dut_i.u_bus.u_assert.fail_cnt;
        $display("Errors: data %0d, status %0d, flag %0d, other %0d", data_errs,
                 status_errs, flag_errs, other_errs);
        if (data_errs + status_errs + flag_errs + other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
hw/i2s_pkg.sv
hw/i2s_rx.sv
hw/sample_fifo.sv
hw/ahbl_i2s.sv
hw/i2s_top.sv
testbench/i2s_tb_assert.sv
testbench/i2s_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module i2s_tb -f sources.f -o i2s_sim

# Assertion failures are counted by the testbench instead of stopping the run
./obj_dir/i2s_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi
